// ==== design/dbg_cfg.svh ====
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// cpu state field widths.
`define DBG_PC_W      20
`define DBG_NIB_W     4
`define DBG_ST_W      16

// text and buffer geometry.
`define DBG_CHAR_W    8
`define DBG_ADDR_W    7
`define DBG_BUF_DEPTH (1 << `DBG_ADDR_W)
`define DBG_TEXT_LEN  66

// digit index inside one segment, wide enough for the 16 ST bits.
`define DBG_IDX_W     4

`endif

// ==== design/dbg_pkg.sv ====
`include "dbg_cfg.svh"

package dbg_pkg;

    // cpu state captured on an accepted trigger.
    typedef struct packed {
        logic [`DBG_PC_W-1:0]  pc;
        logic                  carry;
        logic                  dec_mode;
        logic [`DBG_NIB_W-1:0] p;
        logic [`DBG_NIB_W-1:0] hst;
        logic [`DBG_ST_W-1:0]  st;
    } cpu_snapshot_t;

    // text segments, in output order.
    typedef enum logic [3:0] {
        SEG_NL0,
        SEG_PC_LBL,
        SEG_PC_HEX,
        SEG_CARRY_LBL,
        SEG_CARRY,
        SEG_MODE_LBL,
        SEG_MODE,
        SEG_NL1,
        SEG_P_LBL,
        SEG_P_HEX,
        SEG_HST_LBL,
        SEG_HST_BIN,
        SEG_ST_LBL,
        SEG_ST_BIN,
        SEG_NL2
    } seg_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_FORMAT,
        PH_STREAM
    } dbg_phase_t;

endpackage

// ==== design/dbg_sequencer.sv ====
`timescale 1ns/10ps
`include "dbg_cfg.svh"

module dbg_sequencer (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_trigger,
    input  logic                   i_seg_last,
    input  logic                   i_stream_done,
    output dbg_pkg::dbg_phase_t    o_phase,
    output dbg_pkg::seg_t          o_seg,
    output logic [`DBG_IDX_W-1:0]  o_seg_len,
    output logic                   o_capture,
    output logic                   o_wr_en,
    output logic                   o_seg_next
);

    // last digit index of each segment, i.e. its length minus one.
    function automatic logic [`DBG_IDX_W-1:0] seg_last_idx(input dbg_pkg::seg_t seg);
        case (seg)
            dbg_pkg::SEG_NL0:       return 4'd1;
            dbg_pkg::SEG_PC_LBL:    return 4'd3;
            dbg_pkg::SEG_PC_HEX:    return 4'd4;
            dbg_pkg::SEG_CARRY_LBL: return 4'd7;
            dbg_pkg::SEG_CARRY:     return 4'd0;
            dbg_pkg::SEG_MODE_LBL:  return 4'd3;
            dbg_pkg::SEG_MODE:      return 4'd2;
            dbg_pkg::SEG_NL1:       return 4'd1;
            dbg_pkg::SEG_P_LBL:     return 4'd2;
            dbg_pkg::SEG_P_HEX:     return 4'd0;
            dbg_pkg::SEG_HST_LBL:   return 4'd5;
            dbg_pkg::SEG_HST_BIN:   return 4'd3;
            dbg_pkg::SEG_ST_LBL:    return 4'd4;
            dbg_pkg::SEG_ST_BIN:    return 4'd15;
            default:                return 4'd1;
        endcase
    endfunction

    dbg_pkg::dbg_phase_t phase_q;
    dbg_pkg::seg_t       seg_q;

    assign o_phase   = phase_q;
    assign o_seg     = seg_q;
    assign o_seg_len = seg_last_idx(seg_q);

    // trigger is only looked at while idle.
    assign o_capture  = (phase_q == dbg_pkg::PH_IDLE) && i_trigger;
    // one character per clock for the whole format phase.
    assign o_wr_en    = (phase_q == dbg_pkg::PH_FORMAT);
    assign o_seg_next = o_wr_en && i_seg_last;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phase_q <= dbg_pkg::PH_IDLE;
            seg_q   <= dbg_pkg::SEG_NL0;
        end else begin
            case (phase_q)
                dbg_pkg::PH_IDLE: begin
                    if (o_capture) begin
                        phase_q <= dbg_pkg::PH_FORMAT;
                        seg_q   <= dbg_pkg::SEG_NL0;
                    end
                end
                dbg_pkg::PH_FORMAT: begin
                    if (o_seg_next) begin
                        // final LF CR written, text is complete.
                        if (seg_q == dbg_pkg::SEG_NL2) begin
                            phase_q <= dbg_pkg::PH_STREAM;
                        end else begin
                            seg_q <= dbg_pkg::seg_t'(seg_q + 4'd1);
                        end
                    end
                end
                dbg_pkg::PH_STREAM: begin
                    if (i_stream_done) begin
                        phase_q <= dbg_pkg::PH_IDLE;
                    end
                end
                default: begin
                    phase_q <= dbg_pkg::PH_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== design/dbg_pos_counter.sv ====
`timescale 1ns/10ps
`include "dbg_cfg.svh"

module dbg_pos_counter (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_start,
    input  logic                   i_wr_en,
    input  logic [`DBG_IDX_W-1:0]  i_seg_len,
    output logic [`DBG_ADDR_W-1:0] o_wr_addr,
    output logic [`DBG_IDX_W-1:0]  o_index,
    output logic                   o_seg_last
);

    // i_seg_len carries the last index of the segment.
    assign o_seg_last = (o_index == i_seg_len);

    always_ff @(posedge i_clk) begin
        if (i_reset || i_start) begin
            o_wr_addr <= '0;
            o_index   <= '0;
        end else if (i_wr_en) begin
            o_wr_addr <= o_wr_addr + 1'b1;
            // restart digit count for the next segment.
            if (o_seg_last) begin
                o_index <= '0;
            end else begin
                o_index <= o_index + 1'b1;
            end
        end
    end

endmodule

// ==== design/dbg_char_formatter.sv ====
`timescale 1ns/10ps
`include "dbg_cfg.svh"

module dbg_char_formatter (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_capture,
    input  dbg_pkg::cpu_snapshot_t  i_snapshot,
    input  dbg_pkg::seg_t           i_seg,
    input  logic [`DBG_IDX_W-1:0]   i_index,
    output logic [`DBG_CHAR_W-1:0]  o_char
);

    // upper-case ascii hex digit.
    function automatic logic [7:0] hex_char(input logic [`DBG_NIB_W-1:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end
        return 8'h37 + {4'h0, nib};
    endfunction

    // character idx of a label, counted from the left.
    function automatic logic [7:0] label_char(input logic [63:0] text,
                                              input int unsigned len,
                                              input logic [`DBG_IDX_W-1:0] idx);
        int unsigned pos;
        if (idx >= len) begin
            return " ";
        end
        pos = len - 1 - idx;
        return text[pos*8 +: 8];
    endfunction

    dbg_pkg::cpu_snapshot_t snap_q;
    logic [2:0]             pc_pos;
    logic [`DBG_NIB_W-1:0]  pc_nib;
    logic                   hst_bit;
    logic                   st_bit;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            snap_q <= '0;
        end else if (i_capture) begin
            snap_q <= i_snapshot;
        end
    end

    // digits come out most significant first.
    assign pc_pos  = 3'(`DBG_PC_W / `DBG_NIB_W - 1) - i_index[2:0];
    assign pc_nib  = snap_q.pc[pc_pos*`DBG_NIB_W +: `DBG_NIB_W];
    assign hst_bit = snap_q.hst[2'd3 - i_index[1:0]];
    assign st_bit  = snap_q.st[4'd15 - i_index];

    always_comb begin
        case (i_seg)
            dbg_pkg::SEG_NL0, dbg_pkg::SEG_NL1, dbg_pkg::SEG_NL2: begin
                o_char = (i_index == '0) ? 8'h0a : 8'h0d;
            end
            dbg_pkg::SEG_PC_LBL:    o_char = label_char("PC: ", 4, i_index);
            dbg_pkg::SEG_PC_HEX:    o_char = hex_char(pc_nib);
            dbg_pkg::SEG_CARRY_LBL: o_char = label_char(" Carry: ", 8, i_index);
            dbg_pkg::SEG_CARRY:     o_char = snap_q.carry ? "1" : "0";
            dbg_pkg::SEG_MODE_LBL:  o_char = label_char(" h: ", 4, i_index);
            dbg_pkg::SEG_MODE: begin
                // DEC or HEX differ only in the outer letters.
                if (snap_q.dec_mode) begin
                    o_char = label_char("DEC", 3, i_index);
                end else begin
                    o_char = label_char("HEX", 3, i_index);
                end
            end
            dbg_pkg::SEG_P_LBL:     o_char = label_char("P: ", 3, i_index);
            dbg_pkg::SEG_P_HEX:     o_char = hex_char(snap_q.p);
            dbg_pkg::SEG_HST_LBL:   o_char = label_char(" HST: ", 6, i_index);
            dbg_pkg::SEG_HST_BIN:   o_char = hst_bit ? "1" : "0";
            dbg_pkg::SEG_ST_LBL:    o_char = label_char(" ST: ", 5, i_index);
            dbg_pkg::SEG_ST_BIN:    o_char = st_bit ? "1" : "0";
            default:                o_char = " ";
        endcase
    end

endmodule

// ==== design/dbg_text_buffer.sv ====
`timescale 1ns/10ps
`include "dbg_cfg.svh"

module dbg_text_buffer (
    input  logic                   i_clk,
    input  logic                   i_wr_en,
    input  logic [`DBG_ADDR_W-1:0] i_wr_addr,
    input  logic [`DBG_CHAR_W-1:0] i_wr_data,
    input  logic                   i_rd_en,
    input  logic [`DBG_ADDR_W-1:0] i_rd_addr,
    output logic [`DBG_CHAR_W-1:0] o_rd_data
);

    logic [`DBG_CHAR_W-1:0] mem [`DBG_BUF_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // read data holds between reads.
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

// ==== design/dbg_char_streamer.sv ====
`timescale 1ns/10ps
`include "dbg_cfg.svh"

module dbg_char_streamer (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  dbg_pkg::dbg_phase_t    i_phase,
    input  logic                   i_serial_busy,
    input  logic [`DBG_CHAR_W-1:0] i_rd_data,
    output logic                   o_rd_en,
    output logic [`DBG_ADDR_W-1:0] o_rd_addr,
    output logic [`DBG_CHAR_W-1:0] o_char,
    output logic                   o_char_valid,
    output logic                   o_stream_done
);

    localparam logic [`DBG_ADDR_W-1:0] TEXT_END = `DBG_TEXT_LEN;

    logic [`DBG_ADDR_W-1:0] rd_ptr;
    logic                   rd_pending;
    logic                   in_stream;

    assign in_stream = (i_phase == dbg_pkg::PH_STREAM);

    // the strobe is the cycle the read data lands.
    assign o_char_valid = rd_pending;
    assign o_char       = i_rd_data;
    assign o_rd_addr    = rd_ptr;

    // one read at a time, never while the transmitter is busy.
    assign o_rd_en = in_stream && !rd_pending && !i_serial_busy && (rd_ptr != TEXT_END);

    // pointer already moved past the last character.
    assign o_stream_done = rd_pending && (rd_ptr == TEXT_END);

    always_ff @(posedge i_clk) begin
        if (i_reset || !in_stream) begin
            rd_ptr     <= '0;
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= o_rd_en;
            if (o_rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== design/dbg_top.sv ====
`timescale 1ns/10ps
`include "dbg_cfg.svh"

module dbg_top (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_trigger,
    input  dbg_pkg::cpu_snapshot_t  i_snapshot,
    input  logic                    i_serial_busy,
    output logic [`DBG_CHAR_W-1:0]  o_char,
    output logic                    o_char_valid,
    output logic                    o_busy
);

    dbg_pkg::dbg_phase_t    phase;
    dbg_pkg::seg_t          seg;
    logic                   capture;
    logic                   wr_en;
    logic [`DBG_IDX_W-1:0]  seg_len;
    logic                   seg_last;
    logic [`DBG_ADDR_W-1:0] wr_addr;
    logic [`DBG_IDX_W-1:0]  index;
    logic [`DBG_CHAR_W-1:0] fmt_char;
    logic                   rd_en;
    logic [`DBG_ADDR_W-1:0] rd_addr;
    logic [`DBG_CHAR_W-1:0] rd_data;
    logic                   stream_done;

    // busy for the whole format and stream run.
    assign o_busy = (phase != dbg_pkg::PH_IDLE);

    dbg_sequencer u_sequencer (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_trigger      (i_trigger),
        .i_seg_last     (seg_last),
        .i_stream_done  (stream_done),
        .o_phase        (phase),
        .o_seg          (seg),
        .o_seg_len      (seg_len),
        .o_capture      (capture),
        .o_wr_en        (wr_en),
        .o_seg_next     ()
    );

    dbg_pos_counter u_counter (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_start        (capture),
        .i_wr_en        (wr_en),
        .i_seg_len      (seg_len),
        .o_wr_addr      (wr_addr),
        .o_index        (index),
        .o_seg_last     (seg_last)
    );

    dbg_char_formatter u_formatter (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_capture      (capture),
        .i_snapshot     (i_snapshot),
        .i_seg          (seg),
        .i_index        (index),
        .o_char         (fmt_char)
    );

    dbg_text_buffer u_buffer (
        .i_clk          (i_clk),
        .i_wr_en        (wr_en),
        .i_wr_addr      (wr_addr),
        .i_wr_data      (fmt_char),
        .i_rd_en        (rd_en),
        .i_rd_addr      (rd_addr),
        .o_rd_data      (rd_data)
    );

    dbg_char_streamer u_streamer (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_phase        (phase),
        .i_serial_busy  (i_serial_busy),
        .i_rd_data      (rd_data),
        .o_rd_en        (rd_en),
        .o_rd_addr      (rd_addr),
        .o_char         (o_char),
        .o_char_valid   (o_char_valid),
        .o_stream_done  (stream_done)
    );

endmodule

// ==== bench/dbg_checker.sv ====
`timescale 1ns/10ps

module dbg_checker (
    input logic i_clk,
    input logic i_reset,
    input logic i_serial_busy,
    input logic i_char_valid,
    input logic i_busy
);

    // failures seen so far, polled by the testbench.
    int fail_count;

    initial begin
        fail_count = 0;
    end

    // each strobe is a single-cycle pulse.
    a_valid_single: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_char_valid |=> !i_char_valid
    ) else begin
        $error("o_char_valid high on two consecutive cycles");
        fail_count++;
    end

    // a read decision taken under back-pressure must not produce a strobe.
    a_busy_holds: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (i_busy && !i_char_valid && i_serial_busy) |=> !i_char_valid
    ) else begin
        $error("o_char_valid rose after a read decision with i_serial_busy high");
        fail_count++;
    end

    // busy cleared by reset.
    a_reset_idle: assert property (
        @(posedge i_clk)
        i_reset |=> !i_busy
    ) else begin
        $error("o_busy high while in reset");
        fail_count++;
    end

endmodule

bind dbg_top dbg_checker u_checker (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_serial_busy  (i_serial_busy),
    .i_char_valid   (o_char_valid),
    .i_busy         (o_busy)
);

// ==== bench/dbg_tb.sv ====
`timescale 1ns/10ps
`include "dbg_cfg.svh"

module dbg_tb;

    localparam int DUMPS      = 20;
    localparam int WAIT_LIMIT = 2000;
    localparam int SNAP_W     = $bits(dbg_pkg::cpu_snapshot_t);

    logic                   i_clk;
    logic                   i_reset;
    logic                   i_trigger;
    dbg_pkg::cpu_snapshot_t i_snapshot;
    logic                   i_serial_busy;
    logic [`DBG_CHAR_W-1:0] o_char;
    logic                   o_char_valid;
    logic                   o_busy;

    logic [31:0]  lfsr_state;
    logic [63:0]  busy_bits;
    byte unsigned exp_q[$];
    int           dump_strobes;
    int           total_strobes;
    logic         last_strobe_seen;

    dbg_top u_dut (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_trigger      (i_trigger),
        .i_snapshot     (i_snapshot),
        .i_serial_busy  (i_serial_busy),
        .o_char         (o_char),
        .o_char_valid   (o_char_valid),
        .o_busy         (o_busy)
    );

    always #50 i_clk = ~i_clk;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic string line_end();
        return $sformatf("%c%c", 8'h0a, 8'h0d);
    endfunction

    // expected dump text for one snapshot.
    function automatic string expected_text(input dbg_pkg::cpu_snapshot_t s);
        string pc_txt;
        string p_txt;
        string carry_txt;
        string mode_txt;
        string txt;
        pc_txt = $sformatf("%h", s.pc);
        p_txt  = $sformatf("%h", s.p);
        if (s.carry) begin
            carry_txt = "1";
        end else begin
            carry_txt = "0";
        end
        if (s.dec_mode) begin
            mode_txt = "DEC";
        end else begin
            mode_txt = "HEX";
        end
        txt = {line_end(), "PC: ", pc_txt.toupper(), " Carry: ", carry_txt, " h: ", mode_txt};
        txt = {txt, line_end(), "P: ", p_txt.toupper(), " HST: ", $sformatf("%b", s.hst)};
        txt = {txt, " ST: ", $sformatf("%b", s.st), line_end()};
        return txt;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic wait_idle(input string ctx);
        int cycles;
        cycles = 0;
        while (o_busy !== 1'b0) begin
            if (cycles == WAIT_LIMIT) begin
                fail_run($sformatf("timeout waiting for o_busy to fall %s", ctx));
            end
            @(negedge i_clk);
            cycles++;
        end
    endtask

    task automatic wait_strobes(input int count);
        int cycles;
        cycles = 0;
        while (dump_strobes < count) begin
            if (cycles == WAIT_LIMIT) begin
                fail_run($sformatf("timeout waiting for %0d character strobes", count));
            end
            @(negedge i_clk);
            cycles++;
        end
    endtask

    // called on a falling edge, returns on the next one.
    task automatic pulse_trigger(input dbg_pkg::cpu_snapshot_t s);
        i_snapshot = s;
        i_trigger  = 1'b1;
        @(negedge i_clk);
        i_trigger  = 1'b0;
    endtask

    task automatic make_snapshot(input int k, output dbg_pkg::cpu_snapshot_t s);
        logic [63:0] bits;
        @(posedge i_clk);
        take_bits(SNAP_W, bits);
        s = dbg_pkg::cpu_snapshot_t'(bits[SNAP_W-1:0]);
        // first four dumps pin both modes.
        if (k < 2) begin
            s.dec_mode = 1'b1;
        end else if (k < 4) begin
            s.dec_mode = 1'b0;
        end
    endtask

    task automatic run_dump(input dbg_pkg::cpu_snapshot_t s, input bit extra_trigger);
        string txt;
        txt = expected_text(s);
        @(negedge i_clk);
        for (int i = 0; i < txt.len(); i++) begin
            exp_q.push_back(txt[i]);
        end
        dump_strobes = 0;
        pulse_trigger(s);
        // snapshot was taken on the accepting edge.
        i_snapshot = ~s;
        check_value("o_busy", o_busy, 1'b1);
        if (extra_trigger) begin
            repeat (20) @(negedge i_clk);
            pulse_trigger(~s);
            wait_strobes(10);
            pulse_trigger(~s);
        end
        wait_idle("after a dump");
        check_value("strobes per dump", dump_strobes, `DBG_TEXT_LEN);
        check_value("characters left over", exp_q.size(), 0);
        // no second dump follows a trigger given while busy.
        repeat (8) begin
            @(negedge i_clk);
            check_value("o_busy", o_busy, 1'b0);
        end
    endtask

    // busy pattern from the shared lfsr, one bit per cycle.
    always @(negedge i_clk) begin
        take_bits(1, busy_bits);
        i_serial_busy = busy_bits[0];
    end

    always @(posedge i_clk) begin
        if (!i_reset) begin
            if (u_dut.u_checker.fail_count != 0) begin
                fail_run("a protocol assertion in the bound checker failed");
            end
            if (last_strobe_seen) begin
                check_value("o_busy after last strobe", o_busy, 1'b0);
            end
            last_strobe_seen = 1'b0;
            if (o_char_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    fail_run("character strobe seen with no dump in progress");
                end
                check_value("o_char", o_char, exp_q.pop_front());
                dump_strobes++;
                total_strobes++;
                last_strobe_seen = (dump_strobes == `DBG_TEXT_LEN);
            end else if (o_char_valid !== 1'b0) begin
                fail_run("o_char_valid is unknown after reset");
            end
        end
    end

    initial begin
        dbg_pkg::cpu_snapshot_t snap;
        i_clk            = 1'b0;
        i_reset          = 1'b1;
        i_trigger        = 1'b0;
        i_snapshot       = '0;
        i_serial_busy    = 1'b0;
        lfsr_state       = 32'he82e185d;
        dump_strobes     = 0;
        total_strobes    = 0;
        last_strobe_seen = 1'b0;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        // quiet while no trigger arrives.
        repeat (20) begin
            @(negedge i_clk);
            check_value("o_busy", o_busy, 1'b0);
            check_value("o_char_valid", o_char_valid, 1'b0);
        end
        for (int k = 0; k < DUMPS; k++) begin
            make_snapshot(k, snap);
            run_dump(snap, (k % 4) == 3);
        end
        if (total_strobes == DUMPS * `DBG_TEXT_LEN && u_dut.u_checker.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("wrong strobe total or checker failures at end of run");
            $display("Verification failed");
            $fatal(1, "end of run check failed");
        end
    end

endmodule

// ==== files.f ====
+incdir+design
design/dbg_pkg.sv
design/dbg_sequencer.sv
design/dbg_pos_counter.sv
design/dbg_char_formatter.sv
design/dbg_text_buffer.sv
design/dbg_char_streamer.sv
design/dbg_top.sv
bench/dbg_checker.sv
bench/dbg_tb.sv
